// ==== rtl/flag_read_pkg.sv ====
package flag_read_pkg;

   // list values and the compared input stream
   localparam int data_w = 32;

   // external data bus
   localparam int axi_addr_w = 32;
   localparam int len_w = 8;

   // internal memory, top bit picks the bank
   localparam int default_addr_w = 10;

   // width of each address generator setting
   localparam int cfg_w = 10;

   // address generator settings, 50 bits in all
   typedef struct packed {
      logic [cfg_w-1:0] iterations;
      logic [cfg_w-1:0] period;
      logic [cfg_w-1:0] duty;
      logic [cfg_w-1:0] shift;
      logic [cfg_w-1:0] incr;
   } gen_cfg_t;

   // cycles from read address to read data in ping_pong_mem
   localparam int mem_rd_latency = 1;

endpackage

// ==== rtl/mem_port_if.sv ====
`timescale 1ns/1ns

interface mem_port_if #(
   parameter int addr_w = flag_read_pkg::default_addr_w,
   parameter int data_w = flag_read_pkg::data_w
);

   logic              en;
   logic              we;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] wdata;
   logic [data_w-1:0] rdata;

   // block that issues accesses
   modport owner (output en, output we, output addr, output wdata, input rdata);

   // memory side
   modport memory (input en, input we, input addr, input wdata, output rdata);

endinterface

// ==== rtl/ping_pong_mem.sv ====
`timescale 1ns/1ns

module ping_pong_mem #(
   parameter int addr_w = flag_read_pkg::default_addr_w,
   parameter bit mem_init_zero = 1'b1
) (
   input logic        clk,
   input logic        rst,
   input logic        run,
   mem_port_if.memory wr_port,
   mem_port_if.memory rd_port
);
   import flag_read_pkg::*;

   logic [data_w-1:0] mem [2**addr_w];
   logic              bank;
   logic [addr_w-1:0] wr_addr;
   logic [addr_w-1:0] rd_addr;

   // swap halves at the start of each run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank <= 1'b0;
      end else if (run) begin
         bank <= ~bank;
      end
   end

   // loader fills one half while the scanner reads the other
   assign wr_addr = {bank, wr_port.addr[addr_w-2:0]};
   assign rd_addr = {~bank, rd_port.addr[addr_w-2:0]};

   initial begin
      if (mem_init_zero) begin
         for (int i = 0; i < 2**addr_w; i++) begin
            mem[i] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (wr_port.en) begin
         if (wr_port.we) begin
            mem[wr_addr] <= wr_port.wdata;
         end
      end
   end

   always @(posedge clk) begin
      if (rd_port.en && !rd_port.we) begin
         rd_port.rdata <= mem[rd_addr];
      end
   end

endmodule

// ==== rtl/load_fsm.sv ====
`timescale 1ns/1ns

module load_fsm (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run,
   input  logic                                running,
   input  logic                                databus_ready,
   input  logic [flag_read_pkg::data_w-1:0]     databus_rdata,
   input  logic                                databus_last,
   input  logic [flag_read_pkg::axi_addr_w-1:0] ext_addr,
   input  logic [flag_read_pkg::len_w-1:0]      length,
   output logic                                databus_valid,
   output logic [flag_read_pkg::axi_addr_w-1:0] databus_addr,
   output logic [flag_read_pkg::len_w-1:0]      databus_len,
   output logic                                wr_word,
   output logic [31:0]                         loaded_count,
   mem_port_if.owner                           wr_port
);

   typedef enum logic [1:0] {
      idle,
      burst,
      hold
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   xfer;

   // valid comes straight from the state register
   assign databus_valid = (state == burst);
   assign xfer = databus_valid && databus_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            state_nxt = idle;
         end
         burst: begin
            if (xfer && databus_last) begin
               state_nxt = idle;
            end else if (!running) begin
               state_nxt = hold;
            end
         end
         hold: begin
            if (running) begin
               state_nxt = burst;
            end
         end
         default: begin
            state_nxt = idle;
         end
      endcase
      // a new run restarts the burst from any state
      if (run) begin
         state_nxt = burst;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= idle;
         databus_addr <= '0;
         loaded_count <= '0;
      end else begin
         state <= state_nxt;
         if (run) begin
            databus_addr <= ext_addr;
            loaded_count <= '0;
         end else if (xfer) begin
            loaded_count <= loaded_count + 32'd1;
         end
      end
   end

   assign databus_len = length;

   // each accepted word is written in its transfer cycle
   assign wr_word = xfer;
   assign wr_port.en = xfer;
   assign wr_port.we = 1'b1;
   assign wr_port.wdata = databus_rdata;

endmodule

// ==== rtl/write_addr_gen.sv ====
`timescale 1ns/1ns

module write_addr_gen #(
   parameter int addr_w = flag_read_pkg::default_addr_w
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run,
   input  flag_read_pkg::gen_cfg_t cfg,
   input  logic                    wr_word,
   output logic [addr_w-1:0]       gen_addr
);
   import flag_read_pkg::*;

   logic [cfg_w-1:0]  per_cnt;
   logic [cfg_w-1:0]  iter_cnt;
   logic [addr_w-1:0] base;
   logic [addr_w-1:0] base_nxt;
   logic              active;
   logic              period_end;
   logic              last_iter;

   assign base_nxt = base + addr_w'(cfg.shift);

   // compare against count plus one so a zero setting wraps
   assign period_end = (per_cnt + cfg_w'(1) == cfg.period);
   assign last_iter = (iter_cnt + cfg_w'(1) == cfg.iterations);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         per_cnt <= '0;
         iter_cnt <= '0;
         base <= '0;
         gen_addr <= '0;
         active <= 1'b0;
      end else if (run) begin
         per_cnt <= '0;
         iter_cnt <= '0;
         base <= '0;
         gen_addr <= '0;
         active <= (cfg.iterations != '0);
      end else if (wr_word && active) begin
         if (period_end) begin
            per_cnt <= '0;
            if (last_iter) begin
               // out of iterations, keep the last address
               active <= 1'b0;
            end else begin
               iter_cnt <= iter_cnt + cfg_w'(1);
               base <= base_nxt;
               gen_addr <= base_nxt;
            end
         end else begin
            per_cnt <= per_cnt + cfg_w'(1);
            // only the first duty words of a period step
            if (per_cnt < cfg.duty) begin
               gen_addr <= gen_addr + addr_w'(cfg.incr);
            end
         end
      end
   end

endmodule

// ==== rtl/value_scanner.sv ====
`timescale 1ns/1ns

module value_scanner #(
   parameter int addr_w = flag_read_pkg::default_addr_w
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            run,
   input  logic                            advance,
   output logic [flag_read_pkg::data_w-1:0] current_value,
   output logic                            current_valid,
   mem_port_if.owner                       rd_port
);
   import flag_read_pkg::*;

   logic [addr_w-1:0]         scan_addr;
   logic [mem_rd_latency-1:0] valid_sr;

   // list position, back to the start on every run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         scan_addr <= '0;
      end else if (run) begin
         scan_addr <= '0;
      end else if (advance) begin
         scan_addr <= scan_addr + addr_w'(1);
      end
   end

   // data is stale until the read of the new address returns
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_sr <= '0;
      end else if (run || advance) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= (valid_sr << 1) | mem_rd_latency'(1);
      end
   end

   assign rd_port.en = 1'b1;
   assign rd_port.we = 1'b0;
   assign rd_port.addr = scan_addr;
   assign rd_port.wdata = '0;

   assign current_value = rd_port.rdata;
   assign current_valid = valid_sr[mem_rd_latency-1];

endmodule

// ==== rtl/match_timer.sv ====
`timescale 1ns/1ns

module match_timer (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            run,
   input  logic                            running,
   input  logic                            disabled,
   input  logic [flag_read_pkg::data_w-1:0] in0,
   input  logic [flag_read_pkg::data_w-1:0] current_value,
   input  logic                            current_valid,
   input  logic [31:0]                     loaded_count,
   input  logic [31:0]                     delay0,
   output logic                            advance,
   output logic [flag_read_pkg::data_w-1:0] out0,
   output logic                            done
);
   import flag_read_pkg::*;

   logic [31:0] delay_cnt;
   logic [31:0] need;
   logic        compare_en;

   assign compare_en = running && (delay_cnt == '0) && (need != '0) && current_valid;
   assign advance = compare_en && (in0 == current_value);

   // flag word follows the match, masked when disabled
   assign out0 = {data_w{advance && !disabled}};
   assign done = (need == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_cnt <= '0;
      end else if (run) begin
         delay_cnt <= delay0;
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 32'd1;
      end
   end

   // matches still owed against the previous load
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         need <= '0;
      end else if (run) begin
         need <= loaded_count;
      end else if (advance) begin
         need <= need - 32'd1;
      end
   end

endmodule

// ==== rtl/timed_flag_read.sv ====
`timescale 1ns/1ns

module timed_flag_read #(
   parameter int addr_w = flag_read_pkg::default_addr_w,
   parameter bit mem_init_zero = 1'b1
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run,
   input  logic                                running,
   input  logic                                disabled,
   input  logic                                databus_ready,
   input  logic [flag_read_pkg::data_w-1:0]     databus_rdata,
   input  logic                                databus_last,
   input  logic [flag_read_pkg::axi_addr_w-1:0] ext_addr,
   input  logic [flag_read_pkg::len_w-1:0]      length,
   input  logic [flag_read_pkg::cfg_w-1:0]      iterations,
   input  logic [flag_read_pkg::cfg_w-1:0]      period,
   input  logic [flag_read_pkg::cfg_w-1:0]      duty,
   input  logic [flag_read_pkg::cfg_w-1:0]      shift,
   input  logic [flag_read_pkg::cfg_w-1:0]      incr,
   input  logic [31:0]                         delay0,
   input  logic [flag_read_pkg::data_w-1:0]     in0,
   output logic                                databus_valid,
   output logic [flag_read_pkg::axi_addr_w-1:0] databus_addr,
   output logic [flag_read_pkg::len_w-1:0]      databus_len,
   output logic [flag_read_pkg::data_w-1:0]     out0,
   output logic                                done
);
   import flag_read_pkg::*;

   gen_cfg_t          cfg;
   logic              wr_word;
   logic [31:0]       loaded_count;
   logic [addr_w-1:0] gen_addr;
   logic              advance;
   logic [data_w-1:0] current_value;
   logic              current_valid;

   mem_port_if #(.addr_w(addr_w), .data_w(data_w)) wr_port ();
   mem_port_if #(.addr_w(addr_w), .data_w(data_w)) rd_port ();

   assign cfg = '{
      iterations: iterations,
      period:     period,
      duty:       duty,
      shift:      shift,
      incr:       incr
   };

   // loader drives the strobe and data, the generator the address
   assign wr_port.addr = gen_addr;

   ping_pong_mem #(.addr_w(addr_w), .mem_init_zero(mem_init_zero)) u_mem (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .wr_port (wr_port.memory),
      .rd_port (rd_port.memory)
   );

   load_fsm u_load (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .running       (running),
      .databus_ready (databus_ready),
      .databus_rdata (databus_rdata),
      .databus_last  (databus_last),
      .ext_addr      (ext_addr),
      .length        (length),
      .databus_valid (databus_valid),
      .databus_addr  (databus_addr),
      .databus_len   (databus_len),
      .wr_word       (wr_word),
      .loaded_count  (loaded_count),
      .wr_port       (wr_port.owner)
   );

   write_addr_gen #(.addr_w(addr_w)) u_addr_gen (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfg),
      .wr_word  (wr_word),
      .gen_addr (gen_addr)
   );

   value_scanner #(.addr_w(addr_w)) u_scanner (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .advance       (advance),
      .current_value (current_value),
      .current_valid (current_valid),
      .rd_port       (rd_port.owner)
   );

   match_timer u_match (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .running       (running),
      .disabled      (disabled),
      .in0           (in0),
      .current_value (current_value),
      .current_valid (current_valid),
      .loaded_count  (loaded_count),
      .delay0        (delay0),
      .advance       (advance),
      .out0          (out0),
      .done          (done)
   );

endmodule

// ==== sim/timed_flag_read_props.sv ====
`timescale 1ns/1ns

module timed_flag_read_props (
   input logic                            clk,
   input logic                            rst,
   input logic                            run,
   input logic                            disabled,
   input logic                            databus_valid,
   input logic                            databus_ready,
   input logic                            databus_last,
   input logic [flag_read_pkg::data_w-1:0] out0,
   input logic                            done
);

   int unsigned fail_cnt = 0;

   a_reset_state: assert property (@(posedge clk) rst |-> !databus_valid && done && out0 == '0)
   else begin
      $error("outputs not quiet during reset");
      fail_cnt++;
   end

   // burst ends on the transfer carrying last
   a_burst_end: assert property (@(posedge clk) disable iff (rst)
      databus_valid && databus_ready && databus_last && !run |=> !databus_valid)
   else begin
      $error("databus_valid still high after last transfer");
      fail_cnt++;
   end

   a_idle_low: assert property (@(posedge clk) disable iff (rst)
      !databus_valid && !run |=> !databus_valid)
   else begin
      $error("databus_valid rose without run");
      fail_cnt++;
   end

   a_hold_valid: assert property (@(posedge clk) disable iff (rst)
      databus_valid && !databus_ready && !run |=> databus_valid)
   else begin
      $error("databus_valid dropped without a transfer");
      fail_cnt++;
   end

   // flag word stays zero while disabled
   a_flag_word: assert property (@(posedge clk) disable iff (rst)
      disabled |-> out0 == '0)
   else begin
      $error("out0 raised while disabled");
      fail_cnt++;
   end

   a_done_holds: assert property (@(posedge clk) disable iff (rst) done && !run |=> done)
   else begin
      $error("done fell without run");
      fail_cnt++;
   end

endmodule

// ==== sim/tb_timed_flag_read.sv ====
`timescale 1ns/1ns

module tb_timed_flag_read;
   import flag_read_pkg::*;

   localparam int addr_w = 10;
   localparam int bank_words = 2**(addr_w-1);
   localparam int n_runs = 6;

   // one entry per run
   int len_t[n_runs] = '{12, 16, 20, 8, 1, 5};
   int dly_t[n_runs] = '{0, 5, 0, 20, 3, 2};
   int dis_t[n_runs] = '{0, 0, 1, 0, 0, 0};
   int iter_t[n_runs] = '{1, 4, 2, 1, 1, 3};
   int per_t[n_runs] = '{1023, 4, 5, 1023, 1023, 2};
   int duty_t[n_runs] = '{1023, 2, 5, 1023, 1023, 1};
   int shift_t[n_runs] = '{0, 3, 10, 0, 0, 7};
   int incr_t[n_runs] = '{1, 1, 2, 1, 1, 1};

   logic clk = 1'b0;
   logic rst;
   logic run;
   logic running;
   logic disabled;
   logic databus_ready;
   logic databus_last;
   logic [data_w-1:0] databus_rdata;
   logic [axi_addr_w-1:0] ext_addr;
   logic [len_w-1:0] length;
   logic [cfg_w-1:0] iterations;
   logic [cfg_w-1:0] period;
   logic [cfg_w-1:0] duty;
   logic [cfg_w-1:0] shift;
   logic [cfg_w-1:0] incr;
   logic [31:0] delay0;
   logic [data_w-1:0] in0;
   logic databus_valid;
   logic [axi_addr_w-1:0] databus_addr;
   logic [len_w-1:0] databus_len;
   logic [data_w-1:0] out0;
   logic done;

   // reference model of both banks and the compare side
   logic [data_w-1:0] next_list [256];
   logic [data_w-1:0] bank_img [2][bank_words];
   bit tog = 1'b0;
   int bus_idx = 0;
   int pos = 0;
   int need_m = 0;
   int dly_m = 0;
   int stale_m = 0;
   int prev_len = 0;
   int errors = 0;
   int cycles = 0;
   int limit = 0;

   timed_flag_read #(.addr_w(addr_w), .mem_init_zero(1'b1)) dut (.*);

   bind timed_flag_read timed_flag_read_props props (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .disabled      (disabled),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_last  (databus_last),
      .out0          (out0),
      .done          (done)
   );

   always #5 clk = ~clk;

   // bus side word pointer
   always @(posedge clk) begin
      if (run) begin
         bus_idx <= 0;
      end else if (databus_valid && databus_ready) begin
         bus_idx <= bus_idx + 1;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // where each word of the burst lands in the write bank
   task automatic place_load(input int r);
      int a = 0;
      int base = 0;
      int per = 0;
      int it = 0;
      bit act;
      act = (iter_t[r] != 0);
      for (int k = 0; k < len_t[r]; k++) begin
         bank_img[!tog][a % bank_words] = next_list[k];
         if (act && per + 1 == per_t[r]) begin
            per = 0;
            if (it + 1 == iter_t[r]) begin
               act = 1'b0;
            end else begin
               it++;
               base += shift_t[r];
               a = base;
            end
         end else if (act) begin
            if (per < duty_t[r]) begin
               a += incr_t[r];
            end
            per++;
         end
      end
   endtask

   task automatic step_cycle();
      logic [data_w-1:0] want;
      logic [data_w-1:0] exp_out;
      bit hit;
      databus_ready = ($urandom % 4) != 0;
      databus_rdata = next_list[bus_idx];
      databus_last = (bus_idx == int'(length) - 1);
      want = bank_img[!tog][pos];
      // during the delay the matching value is offered on purpose
      if (need_m != 0 && (dly_m != 0 || ($urandom % 3) != 0)) begin
         in0 = want;
      end else begin
         in0 = want ^ ($urandom | 32'd1);
      end
      #1;
      hit = running && dly_m == 0 && need_m != 0 && stale_m == 0 && in0 == want;
      exp_out = (hit && !disabled) ? '1 : '0;
      assert (out0 === exp_out) else begin
         $display("FAIL out0 expected %h got %h", exp_out, out0);
         errors++;
      end
      assert (done === (need_m == 0)) else begin
         $display("FAIL done expected %h got %h", need_m == 0, done);
         errors++;
      end
      if (run) begin
         tog = !tog;
         pos = 0;
         need_m = prev_len;
         prev_len = int'(length);
         dly_m = int'(delay0);
         stale_m = mem_rd_latency;
      end else begin
         if (hit) begin
            pos++;
            need_m--;
            stale_m = mem_rd_latency;
         end else if (stale_m != 0) begin
            stale_m--;
         end
         if (dly_m != 0) begin
            dly_m--;
         end
      end
   endtask

   task automatic start_run(input int r);
      logic [axi_addr_w-1:0] addr_s;
      int tail = 0;
      @(negedge clk);
      length = len_w'(len_t[r]);
      delay0 = dly_t[r];
      disabled = dis_t[r][0];
      iterations = cfg_w'(iter_t[r]);
      period = cfg_w'(per_t[r]);
      duty = cfg_w'(duty_t[r]);
      shift = cfg_w'(shift_t[r]);
      incr = cfg_w'(incr_t[r]);
      addr_s = $urandom & 32'hffff_fffc;
      ext_addr = addr_s;
      for (int k = 0; k < len_t[r]; k++) begin
         next_list[k] = $urandom;
      end
      place_load(r);
      run = 1'b1;
      step_cycle();
      @(negedge clk);
      run = 1'b0;
      assert (databus_addr === addr_s) else begin
         $display("FAIL databus_addr expected %h got %h", addr_s, databus_addr);
         errors++;
      end
      assert (databus_len === len_w'(len_t[r])) else begin
         $display("FAIL databus_len expected %h got %h", len_w'(len_t[r]), databus_len);
         errors++;
      end
      // address must stay latched from the run cycle
      ext_addr = ~addr_s;
      step_cycle();
      while (tail < 4) begin
         @(negedge clk);
         step_cycle();
         assert (databus_addr === addr_s) else begin
            $display("FAIL databus_addr expected %h got %h", addr_s, databus_addr);
            errors++;
         end
         if (!databus_valid && done) begin
            tail++;
         end
      end
   endtask

   initial begin
      void'($urandom(32'h94c0cf74));
      rst = 1'b1;
      run = 1'b0;
      running = 1'b1;
      disabled = 1'b0;
      databus_ready = 1'b0;
      databus_rdata = '0;
      databus_last = 1'b0;
      ext_addr = '0;
      length = '0;
      iterations = '0;
      period = '0;
      duty = '0;
      shift = '0;
      incr = '0;
      delay0 = '0;
      in0 = '0;
      for (int i = 0; i < bank_words; i++) begin
         bank_img[0][i] = '0;
         bank_img[1][i] = '0;
      end
      for (int r = 0; r < n_runs; r++) begin
         limit += len_t[r] + dly_t[r] + ((r > 0) ? len_t[r-1] : 0);
      end
      limit = 4 * limit + 200;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      for (int r = 0; r < n_runs; r++) begin
         start_run(r);
      end
      @(negedge clk);
      $display("errors: %0d checks, %0d assertions", errors, dut.props.fail_cnt);
      if (errors == 0 && dut.props.fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== timed_flag_read.f ====
rtl/flag_read_pkg.sv
rtl/mem_port_if.sv
rtl/ping_pong_mem.sv
rtl/load_fsm.sv
rtl/write_addr_gen.sv
rtl/value_scanner.sv
rtl/match_timer.sv
rtl/timed_flag_read.sv
sim/timed_flag_read_props.sv
sim/tb_timed_flag_read.sv
